/* dp_aux_settings.svh */
`ifndef DP_AUX_SETTINGS_SVH
`define DP_AUX_SETTINGS_SVH

// AUX address and byte widths
`define AUX_ADDR_WIDTH 20
`define AUX_DATA_WIDTH 8

// Cycles without a reply byte before the transaction fails
`define AUX_REPLY_TIMEOUT 64

// Upper bit of each reply code inside the reply header byte
`define AUX_NATIVE_MSB 5
`define AUX_I2C_MSB 7

`endif

/* dp_aux_req_pkg.sv */
package dp_aux_req_pkg;

    // Request opcode
    // Bit 0 is the read bit and bit 1 the status bit of the I2C nibble
    typedef enum logic [1:0] {
        AUX_CMD_WRITE = 2'b00,
        AUX_CMD_READ  = 2'b01,
        AUX_CMD_WSU   = 2'b10
    } aux_cmd_e;

    // Owner of the outstanding transaction
    typedef enum logic {
        AUX_SRC_LPM = 1'b0,
        AUX_SRC_SPM = 1'b1
    } aux_src_e;

    // Serializer byte position
    typedef enum logic [2:0] {
        SER_IDLE, SER_HDR0, SER_HDR1, SER_HDR2, SER_HDR3, SER_DATA
    } ser_state_e;

endpackage

/* dp_aux_rply_pkg.sv */
package dp_aux_rply_pkg;

    // Reply code
    // Same encoding in the native and the I2C field of the header
    typedef enum logic [1:0] {
        AUX_REPLY_ACK   = 2'b00,
        AUX_REPLY_NACK  = 2'b01,
        AUX_REPLY_DEFER = 2'b10
    } aux_reply_e;

    // Reply parser states
    typedef enum logic [1:0] {
        RP_WAIT_HDR,
        RP_DATA,
        RP_IDLE
    } rply_state_e;

endpackage

/* aux_link_ifs.sv */
`timescale 1ns/1ps
`include "dp_aux_settings.svh"

////////////////////
// Request bus from arbiter to serializer
////////////////////
interface aux_req_if
    import dp_aux_req_pkg::*;
();
    // Held by the arbiter for the whole transaction
    logic                       req_vld;
    logic                       req_native;
    aux_cmd_e                   req_cmd;
    logic [`AUX_ADDR_WIDTH-1:0] req_addr;
    logic [`AUX_DATA_WIDTH-1:0] req_len;
    logic [`AUX_DATA_WIDTH-1:0] req_data;
    // One cycle after the last request byte left
    logic                       req_sent;

    modport arbiter (output req_vld, req_native, req_cmd, req_addr, req_len, req_data,
                     input req_sent);
    modport serializer (input req_vld, req_native, req_cmd, req_addr, req_len, req_data,
                        output req_sent);
    // Parser only needs to know when to start waiting
    modport monitor (input req_sent);
endinterface

////////////////////
// Reply bus from parser to arbiter
////////////////////
interface aux_rply_if ();
    // Upper nibble of the header byte, both code fields
    logic                       rply_hdr_vld;
    logic [3:0]                 rply_hdr;
    logic                       rply_data_vld;
    logic [`AUX_DATA_WIDTH-1:0] rply_data;
    logic                       rply_timeout;
    logic                       txn_done;

    modport source (output rply_hdr_vld, rply_hdr, rply_data_vld, rply_data, rply_timeout,
                    txn_done);
    modport sink (input rply_hdr_vld, rply_hdr, rply_data_vld, rply_data, rply_timeout,
                  txn_done);
endinterface

/* aux_req_arbiter.sv */
`timescale 1ns/1ps
`include "dp_aux_settings.svh"

module aux_req_arbiter
    import dp_aux_req_pkg::*;
    import dp_aux_rply_pkg::*;
(
    input  logic                       clk_AUX,
    input  logic                       rst_n,
    // Link policy maker
    input  logic                       lpm_transaction_vld,
    input  aux_cmd_e                   lpm_cmd,
    input  logic [`AUX_ADDR_WIDTH-1:0] lpm_addr,
    input  logic [`AUX_DATA_WIDTH-1:0] lpm_len,
    input  logic [`AUX_DATA_WIDTH-1:0] lpm_data,
    output logic                       lpm_accept,
    output aux_reply_e                 lpm_reply_ack,
    output logic                       lpm_reply_ack_vld,
    output logic [`AUX_DATA_WIDTH-1:0] lpm_reply_data,
    output logic                       lpm_reply_data_vld,
    output logic                       ctrl_native_failed,
    // Stream policy maker
    input  logic                       spm_transaction_vld,
    input  aux_cmd_e                   spm_cmd,
    input  logic [`AUX_ADDR_WIDTH-1:0] spm_addr,
    input  logic [`AUX_DATA_WIDTH-1:0] spm_len,
    input  logic [`AUX_DATA_WIDTH-1:0] spm_data,
    output logic                       spm_accept,
    output aux_reply_e                 spm_reply_ack,
    output logic                       spm_reply_ack_vld,
    output logic [`AUX_DATA_WIDTH-1:0] spm_reply_data,
    output logic                       spm_reply_data_vld,
    output logic                       ctrl_i2c_failed,
    aux_req_if.arbiter                 req,
    aux_rply_if.sink                   rply
);

    // Header nibble sits in the upper half of the byte
    localparam int NIB = `AUX_DATA_WIDTH / 2;

    typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_e;

    arb_state_e state;
    aux_src_e   owner;
    logic       lpm_win;
    logic       spm_win;
    aux_reply_e owner_code;

    // Fixed priority, LPM first
    assign lpm_win = (state == ARB_IDLE) && lpm_transaction_vld;
    assign spm_win = (state == ARB_IDLE) && spm_transaction_vld && !lpm_transaction_vld;

    always_ff @(posedge clk_AUX) begin
        if (!rst_n) begin
            state       <= ARB_IDLE;
            owner       <= AUX_SRC_LPM;
            lpm_accept  <= 1'b0;
            spm_accept  <= 1'b0;
            req.req_vld <= 1'b0;
        end else begin
            // Accept pulses together with the rise of req_vld
            lpm_accept <= lpm_win;
            spm_accept <= spm_win;
            case (state)
                ARB_IDLE: begin
                    if (lpm_win || spm_win) begin
                        state       <= ARB_BUSY;
                        owner       <= lpm_win ? AUX_SRC_LPM : AUX_SRC_SPM;
                        req.req_vld <= 1'b1;
                    end
                end
                ARB_BUSY: begin
                    // Free again one cycle after the reply ends
                    if (rply.txn_done) begin
                        state       <= ARB_IDLE;
                        req.req_vld <= 1'b0;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Winner's request held until the next grant
    always_ff @(posedge clk_AUX) begin
        if (lpm_win) begin
            req.req_cmd  <= lpm_cmd;
            req.req_addr <= lpm_addr;
            req.req_len  <= lpm_len;
            req.req_data <= lpm_data;
        end else if (spm_win) begin
            req.req_cmd  <= spm_cmd;
            req.req_addr <= spm_addr;
            req.req_len  <= spm_len;
            req.req_data <= spm_data;
        end
    end

    // LPM speaks native AUX, SPM speaks I2C over AUX
    assign req.req_native = (owner == AUX_SRC_LPM);

    ////////////////////
    // Reply routing to the owner
    ////////////////////
    assign owner_code = (owner == AUX_SRC_LPM) ?
                        aux_reply_e'(rply.rply_hdr[`AUX_NATIVE_MSB-NIB -: 2]) :
                        aux_reply_e'(rply.rply_hdr[`AUX_I2C_MSB-NIB -: 2]);

    assign lpm_reply_ack      = owner_code;
    assign spm_reply_ack      = owner_code;
    assign lpm_reply_data     = rply.rply_data;
    assign spm_reply_data     = rply.rply_data;
    assign lpm_reply_ack_vld  = rply.rply_hdr_vld && (owner == AUX_SRC_LPM);
    assign spm_reply_ack_vld  = rply.rply_hdr_vld && (owner == AUX_SRC_SPM);
    assign lpm_reply_data_vld = rply.rply_data_vld && (owner == AUX_SRC_LPM);
    assign spm_reply_data_vld = rply.rply_data_vld && (owner == AUX_SRC_SPM);
    // Timeout goes only to whoever is waiting
    assign ctrl_native_failed = rply.rply_timeout && (owner == AUX_SRC_LPM);
    assign ctrl_i2c_failed    = rply.rply_timeout && (owner == AUX_SRC_SPM);

    // Reply pulses are routed by owner, so they belong inside a transaction
    a_rply_busy: assert property (@(posedge clk_AUX) disable iff (!rst_n)
        rply.rply_hdr_vld || rply.rply_data_vld || rply.rply_timeout |-> state == ARB_BUSY)
        else $error("Reply pulse seen while arbiter idle");

    // Parser must not close a transaction that was never granted
    a_done_busy: assert property (@(posedge clk_AUX) disable iff (!rst_n)
        rply.txn_done |-> state == ARB_BUSY)
        else $error("txn_done seen while arbiter idle");

endmodule

/* aux_req_serializer.sv */
`timescale 1ns/1ps
`include "dp_aux_settings.svh"

module aux_req_serializer
    import dp_aux_req_pkg::*;
(
    input  logic                       clk_AUX,
    input  logic                       rst_n,
    input  logic                       aux_tx_ready,
    output logic [`AUX_DATA_WIDTH-1:0] aux_tx_byte,
    output logic                       aux_tx_vld,
    output logic                       aux_tx_last,
    aux_req_if.serializer              req
);

    localparam int DW = `AUX_DATA_WIDTH;
    localparam int AW = `AUX_ADDR_WIDTH;

    ser_state_e state;
    logic       req_taken;
    logic       xfer;
    logic       is_read;
    logic       has_data;
    logic [3:0] cmd_nibble;

    assign is_read  = (req.req_cmd == AUX_CMD_READ);
    // Write and write-status-update carry one data byte
    assign has_data = !is_read;

    // Native 1,0,0,R and I2C 0,0,S,R
    assign cmd_nibble = req.req_native ? {1'b1, 2'b00, is_read} :
                        {2'b00, req.req_cmd == AUX_CMD_WSU, is_read};

    // Byte moves only with both sides high
    assign aux_tx_vld = (state != SER_IDLE);
    assign xfer       = aux_tx_vld && aux_tx_ready;

    ////////////////////
    // Byte select by position
    ////////////////////
    always_comb begin
        aux_tx_byte = '0;
        aux_tx_last = 1'b0;
        case (state)
            SER_HDR0: aux_tx_byte = {cmd_nibble, req.req_addr[AW-1 -: AW-2*DW]};
            SER_HDR1: aux_tx_byte = req.req_addr[2*DW-1 -: DW];
            SER_HDR2: aux_tx_byte = req.req_addr[DW-1:0];
            SER_HDR3: begin
                aux_tx_byte = req.req_len;
                aux_tx_last = !has_data;
            end
            SER_DATA: begin
                aux_tx_byte = req.req_data;
                aux_tx_last = 1'b1;
            end
            default: aux_tx_byte = '0;
        endcase
    end

    always_ff @(posedge clk_AUX) begin
        if (!rst_n) begin
            state        <= SER_IDLE;
            req_taken    <= 1'b0;
            req.req_sent <= 1'b0;
        end else begin
            req.req_sent <= xfer && aux_tx_last;
            // Rearm once the arbiter drops the request
            if (!req.req_vld) begin
                req_taken <= 1'b0;
            end
            case (state)
                SER_IDLE: begin
                    if (req.req_vld && !req_taken) begin
                        state     <= SER_HDR0;
                        req_taken <= 1'b1;
                    end
                end
                SER_HDR0: if (xfer) state <= SER_HDR1;
                SER_HDR1: if (xfer) state <= SER_HDR2;
                SER_HDR2: if (xfer) state <= SER_HDR3;
                SER_HDR3: if (xfer) state <= has_data ? SER_DATA : SER_IDLE;
                SER_DATA: if (xfer) state <= SER_IDLE;
                default:  state <= SER_IDLE;
            endcase
        end
    end

    // Stall holds the byte, relies on the arbiter holding the request
    a_stall_stable: assert property (@(posedge clk_AUX) disable iff (!rst_n)
        aux_tx_vld && !aux_tx_ready |=> aux_tx_vld && $stable(aux_tx_byte) && $stable(aux_tx_last))
        else $error("TX byte changed while stalled");

    // Single data byte per write
    a_write_len: assert property (@(posedge clk_AUX) disable iff (!rst_n)
        req.req_vld && has_data |-> req.req_len == '0)
        else $error("Write request with nonzero length");

    a_wsu_i2c: assert property (@(posedge clk_AUX) disable iff (!rst_n)
        req.req_vld && req.req_cmd == AUX_CMD_WSU |-> !req.req_native)
        else $error("Write-status-update on a native request");

endmodule

/* aux_reply_parser.sv */
`timescale 1ns/1ps
`include "dp_aux_settings.svh"

module aux_reply_parser
    import dp_aux_rply_pkg::*;
(
    input  logic                       clk_AUX,
    input  logic                       rst_n,
    input  logic [`AUX_DATA_WIDTH-1:0] aux_rx_byte,
    input  logic                       aux_rx_vld,
    input  logic                       aux_rx_last,
    aux_req_if.monitor                 req,
    aux_rply_if.source                 rply
);

    localparam int TMO_W = $clog2(`AUX_REPLY_TIMEOUT + 1);

    rply_state_e      state;
    logic [TMO_W-1:0] tmo_cnt;
    logic             tmo_hit;

    assign tmo_hit = (tmo_cnt == TMO_W'(`AUX_REPLY_TIMEOUT - 1));

    always_ff @(posedge clk_AUX) begin
        if (!rst_n) begin
            state              <= RP_IDLE;
            tmo_cnt            <= '0;
            rply.rply_hdr_vld  <= 1'b0;
            rply.rply_data_vld <= 1'b0;
            rply.rply_timeout  <= 1'b0;
            rply.txn_done      <= 1'b0;
        end else begin
            // All outputs are single cycle pulses
            rply.rply_hdr_vld  <= 1'b0;
            rply.rply_data_vld <= 1'b0;
            rply.rply_timeout  <= 1'b0;
            rply.txn_done      <= 1'b0;
            case (state)
                RP_IDLE: begin
                    // Stray bytes here are dropped
                    tmo_cnt <= '0;
                    if (req.req_sent) state <= RP_WAIT_HDR;
                end
                RP_WAIT_HDR, RP_DATA: begin
                    if (aux_rx_vld) begin
                        // First byte is the header, the rest data
                        rply.rply_hdr_vld  <= (state == RP_WAIT_HDR);
                        rply.rply_data_vld <= (state == RP_DATA);
                        tmo_cnt            <= '0;
                        state              <= aux_rx_last ? RP_IDLE : RP_DATA;
                        rply.txn_done      <= aux_rx_last;
                    end else if (tmo_hit) begin
                        rply.rply_timeout <= 1'b1;
                        rply.txn_done     <= 1'b1;
                        state             <= RP_IDLE;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                default: state <= RP_IDLE;
            endcase
        end
    end

    ////////////////////
    // Reply payload capture
    ////////////////////
    always_ff @(posedge clk_AUX) begin
        if (aux_rx_vld && state == RP_WAIT_HDR) begin
            rply.rply_hdr <= aux_rx_byte[`AUX_DATA_WIDTH-1 -: 4];
        end
        if (aux_rx_vld) rply.rply_data <= aux_rx_byte;
    end

    // A new request only completes once the previous reply has ended
    a_sent_idle: assert property (@(posedge clk_AUX) disable iff (!rst_n)
        req.req_sent |-> state == RP_IDLE)
        else $error("Request sent while a reply was still awaited");

endmodule

/* dp_aux_link_top.sv */
`timescale 1ns/1ps
`include "dp_aux_settings.svh"

module dp_aux_link_top
    import dp_aux_req_pkg::*;
    import dp_aux_rply_pkg::*;
(
    input  logic                       clk_AUX,
    input  logic                       rst_n,
    // Link policy maker
    input  logic                       lpm_transaction_vld,
    input  aux_cmd_e                   lpm_cmd,
    input  logic [`AUX_ADDR_WIDTH-1:0] lpm_addr,
    input  logic [`AUX_DATA_WIDTH-1:0] lpm_len,
    input  logic [`AUX_DATA_WIDTH-1:0] lpm_data,
    output logic                       lpm_accept,
    output aux_reply_e                 lpm_reply_ack,
    output logic                       lpm_reply_ack_vld,
    output logic [`AUX_DATA_WIDTH-1:0] lpm_reply_data,
    output logic                       lpm_reply_data_vld,
    output logic                       ctrl_native_failed,
    // Stream policy maker
    input  logic                       spm_transaction_vld,
    input  aux_cmd_e                   spm_cmd,
    input  logic [`AUX_ADDR_WIDTH-1:0] spm_addr,
    input  logic [`AUX_DATA_WIDTH-1:0] spm_len,
    input  logic [`AUX_DATA_WIDTH-1:0] spm_data,
    output logic                       spm_accept,
    output aux_reply_e                 spm_reply_ack,
    output logic                       spm_reply_ack_vld,
    output logic [`AUX_DATA_WIDTH-1:0] spm_reply_data,
    output logic                       spm_reply_data_vld,
    output logic                       ctrl_i2c_failed,
    // PHY byte streams
    output logic [`AUX_DATA_WIDTH-1:0] aux_tx_byte,
    output logic                       aux_tx_vld,
    input  logic                       aux_tx_ready,
    output logic                       aux_tx_last,
    input  logic [`AUX_DATA_WIDTH-1:0] aux_rx_byte,
    input  logic                       aux_rx_vld,
    input  logic                       aux_rx_last
);

    aux_req_if  req_bus ();
    aux_rply_if rply_bus ();

    // Request side, reply side and policy maker routing
    aux_req_arbiter    u_arbiter    (.req(req_bus), .rply(rply_bus), .*);
    aux_req_serializer u_serializer (.req(req_bus), .*);
    aux_reply_parser   u_parser     (.req(req_bus), .rply(rply_bus), .*);

endmodule

/* tb_dp_aux_link.sv */
`timescale 1ns/1ps
`include "dp_aux_settings.svh"

module tb_dp_aux_link
    import dp_aux_req_pkg::*;
    import dp_aux_rply_pkg::*;
();

    localparam int N_ENTRIES = 9;
    localparam int MAX_RX    = 4;

    // One row of the stimulus table, first reply data byte in rx[0]
    typedef struct packed {
        aux_src_e                   src;
        aux_cmd_e                   cmd;
        logic [`AUX_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [7:0]                 data;
        logic [7:0]                 hdr;
        int                         nrx;
        logic [MAX_RX-1:0][7:0]     rx;
        logic                       no_reply;
        logic                       with_next;
        aux_reply_e                 exp_ack;
    } entry_t;

    logic                       clk_AUX = 1'b0;
    logic                       rst_n;
    logic                       lpm_transaction_vld, spm_transaction_vld;
    aux_cmd_e                   lpm_cmd, spm_cmd;
    logic [`AUX_ADDR_WIDTH-1:0] lpm_addr, spm_addr;
    logic [7:0]                 lpm_len, lpm_data, spm_len, spm_data;
    logic                       lpm_accept, spm_accept;
    aux_reply_e                 lpm_reply_ack, spm_reply_ack;
    logic                       lpm_reply_ack_vld, spm_reply_ack_vld;
    logic [7:0]                 lpm_reply_data, spm_reply_data;
    logic                       lpm_reply_data_vld, spm_reply_data_vld;
    logic                       ctrl_native_failed, ctrl_i2c_failed;
    logic [7:0]                 aux_tx_byte, aux_rx_byte;
    logic                       aux_tx_vld, aux_tx_ready, aux_tx_last;
    logic                       aux_rx_vld, aux_rx_last;

    entry_t tests [N_ENTRIES];
    string  names [N_ENTRIES];
    int     n_added  = 0;
    int     n_checks = 0;
    int     n_errors = 0;
    // Request of the next row already raised together with this one
    logic   pending  = 1'b0;

    dp_aux_link_top DUT (.*);

    always #4 clk_AUX = ~clk_AUX;

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check(input string name, input string what, input logic [31:0] exp,
                         input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("Fail %s %s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    // Sample point and drive point, 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_AUX);
        #1;
    endtask

    task automatic add_test(input string name, input aux_src_e src, input aux_cmd_e cmd,
                            input logic [19:0] addr, input logic [7:0] len,
                            input logic [7:0] data, input logic [7:0] hdr, input int nrx,
                            input logic [31:0] rx, input logic no_reply,
                            input logic with_next, input aux_reply_e exp_ack);
        names[n_added] = name;
        tests[n_added] = '{src, cmd, addr, len, data, hdr, nrx, rx, no_reply, with_next,
                           exp_ack};
        n_added++;
    endtask

    // Request byte k as the AUX request format defines it
    function automatic logic [7:0] req_byte(input entry_t t, input int k);
        logic [3:0] nib;
        logic       rd;
        rd = (t.cmd == AUX_CMD_READ);
        // Native for LPM, I2C over AUX for SPM
        if (t.src == AUX_SRC_LPM) nib = {3'b100, rd};
        else nib = {2'b00, t.cmd == AUX_CMD_WSU, rd};
        case (k)
            0: return {nib, t.addr[19:16]};
            1: return t.addr[15:8];
            2: return t.addr[7:0];
            3: return t.len;
            default: return t.data;
        endcase
    endfunction

    task automatic raise_request(input entry_t t);
        if (t.src == AUX_SRC_LPM) begin
            lpm_transaction_vld = 1'b1;
            lpm_cmd  = t.cmd;
            lpm_addr = t.addr;
            lpm_len  = t.len;
            lpm_data = t.data;
        end else begin
            spm_transaction_vld = 1'b1;
            spm_cmd  = t.cmd;
            spm_addr = t.addr;
            spm_len  = t.len;
            spm_data = t.data;
        end
    endtask

    ////////////////////
    // One table row, requester and PHY model together
    ////////////////////
    task automatic run_test(input int i);
        entry_t     t;
        logic       is_lpm, own_acc, oth_acc, ack_vld, dat_vld, fail, stray;
        logic       accepted, acked, failed, done;
        aux_reply_e ack;
        logic [7:0] dat;
        int         n_exp, n_tx, n_rx, n_data, gap;
        t        = tests[i];
        is_lpm   = (t.src == AUX_SRC_LPM);
        n_exp    = (t.cmd == AUX_CMD_READ) ? 4 : 5;
        n_tx     = 0;
        n_rx     = 0;
        n_data   = 0;
        gap      = -1;
        accepted = 1'b0;
        acked    = 1'b0;
        failed   = 1'b0;
        done     = 1'b0;
        if (!pending) raise_request(t);
        // Tie case, both requesters raise valid in this same cycle
        if (t.with_next) raise_request(tests[i+1]);
        pending = t.with_next;
        while (!done) begin
            tick();
            own_acc = is_lpm ? lpm_accept : spm_accept;
            oth_acc = is_lpm ? spm_accept : lpm_accept;
            ack_vld = is_lpm ? lpm_reply_ack_vld : spm_reply_ack_vld;
            ack     = is_lpm ? lpm_reply_ack : spm_reply_ack;
            dat_vld = is_lpm ? lpm_reply_data_vld : spm_reply_data_vld;
            dat     = is_lpm ? lpm_reply_data : spm_reply_data;
            fail    = is_lpm ? ctrl_native_failed : ctrl_i2c_failed;
            stray   = is_lpm ? (spm_reply_ack_vld | spm_reply_data_vld | ctrl_i2c_failed) :
                               (lpm_reply_ack_vld | lpm_reply_data_vld | ctrl_native_failed);
            if (oth_acc) check(names[i], "accept while busy", 32'd0, 32'd1);
            if (stray) check(names[i], "pulse to other requester", 32'd0, 32'd1);
            // Requester lets go once accepted
            if (own_acc) begin
                accepted = 1'b1;
                if (is_lpm) lpm_transaction_vld = 1'b0;
                else spm_transaction_vld = 1'b0;
            end
            // Reply bytes, header first, no back-pressure
            aux_rx_vld  = 1'b0;
            aux_rx_last = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (gap == 0 && !t.no_reply && n_rx <= t.nrx) begin
                aux_rx_vld  = 1'b1;
                aux_rx_byte = (n_rx == 0) ? t.hdr : t.rx[n_rx-1];
                aux_rx_last = (n_rx == t.nrx);
                n_rx++;
            end
            // Transmit side with random stalls
            aux_tx_ready = ($urandom % 4) != 0;
            if (aux_tx_vld && aux_tx_ready) begin
                check(names[i], "tx byte", 32'(req_byte(t, n_tx)), 32'(aux_tx_byte));
                check(names[i], "tx last", 32'(n_tx == n_exp - 1), 32'(aux_tx_last));
                n_tx++;
                // Turnaround before the reply starts
                if (n_tx == n_exp) gap = 4;
            end
            if (ack_vld) begin
                check(names[i], "reply ack", 32'(t.exp_ack), 32'(ack));
                acked = 1'b1;
            end
            if (dat_vld) begin
                check(names[i], "reply data", 32'(t.rx[n_data]), 32'(dat));
                n_data++;
            end
            if (fail) begin
                check(names[i], "failed pulse", 32'(t.no_reply), 32'd1);
                failed = 1'b1;
            end
            done = failed || (!t.no_reply && acked && n_data == t.nrx);
        end
        check(names[i], "accepted", 32'd1, 32'(accepted));
        check(names[i], "tx byte count", 32'(n_exp), 32'(n_tx));
        if (t.no_reply) check(names[i], "reply on silent link", 32'd0, 32'(acked));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        void'($urandom(32'h25bb));
        rst_n               = 1'b0;
        lpm_transaction_vld = 1'b0;
        lpm_cmd             = AUX_CMD_WRITE;
        lpm_addr            = '0;
        lpm_len             = '0;
        lpm_data            = '0;
        spm_transaction_vld = 1'b0;
        spm_cmd             = AUX_CMD_WRITE;
        spm_addr            = '0;
        spm_len             = '0;
        spm_data            = '0;
        aux_tx_ready        = 1'b0;
        aux_rx_byte         = '0;
        aux_rx_vld          = 1'b0;
        aux_rx_last         = 1'b0;
        // Header bits 5:4 native code, bits 7:6 I2C code
        add_test("native_write", AUX_SRC_LPM, AUX_CMD_WRITE, 20'h4_0102, 8'h00, 8'h5a,
                 8'h00, 0, 32'h0, 1'b0, 1'b0, AUX_REPLY_ACK);
        add_test("native_read", AUX_SRC_LPM, AUX_CMD_READ, 20'h2_0003, 8'h02, 8'h00,
                 8'h00, 3, 32'h0033_2211, 1'b0, 1'b0, AUX_REPLY_ACK);
        add_test("i2c_wsu_nack", AUX_SRC_SPM, AUX_CMD_WSU, 20'h0_0050, 8'h00, 8'h00,
                 8'h40, 0, 32'h0, 1'b0, 1'b0, AUX_REPLY_NACK);
        add_test("i2c_wsu_defer", AUX_SRC_SPM, AUX_CMD_WSU, 20'h0_0050, 8'h00, 8'h00,
                 8'h80, 0, 32'h0, 1'b0, 1'b0, AUX_REPLY_DEFER);
        // Native NACK on a write carries one byte
        add_test("tie_lpm_write", AUX_SRC_LPM, AUX_CMD_WRITE, 20'h0_0200, 8'h00, 8'hc3,
                 8'h10, 1, 32'h01, 1'b0, 1'b1, AUX_REPLY_NACK);
        add_test("tie_spm_read", AUX_SRC_SPM, AUX_CMD_READ, 20'h0_0050, 8'h00, 8'h00,
                 8'h00, 1, 32'ha5, 1'b0, 1'b0, AUX_REPLY_ACK);
        add_test("native_timeout", AUX_SRC_LPM, AUX_CMD_READ, 20'h0_0100, 8'h00, 8'h00,
                 8'h00, 0, 32'h0, 1'b1, 1'b0, AUX_REPLY_ACK);
        add_test("i2c_timeout", AUX_SRC_SPM, AUX_CMD_WRITE, 20'h0_0050, 8'h00, 8'h77,
                 8'h00, 0, 32'h0, 1'b1, 1'b0, AUX_REPLY_ACK);
        add_test("after_timeout", AUX_SRC_LPM, AUX_CMD_READ, 20'hf_ffff, 8'h00, 8'h00,
                 8'h00, 1, 32'he7, 1'b0, 1'b0, AUX_REPLY_ACK);
        repeat (8) tick();
        rst_n = 1'b1;
        tick();
        check("reset", "lpm_accept", 32'd0, 32'(lpm_accept));
        check("reset", "spm_accept", 32'd0, 32'(spm_accept));
        check("reset", "aux_tx_vld", 32'd0, 32'(aux_tx_vld));
        for (int i = 0; i < N_ENTRIES; i++) run_test(i);
        tick();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, budget per table row
    initial begin
        repeat (N_ENTRIES * (`AUX_REPLY_TIMEOUT + 64)) @(posedge clk_AUX);
        $display("Timeout: the table did not complete within its cycle budget");
        $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
dp_aux_req_pkg.sv
dp_aux_rply_pkg.sv
aux_link_ifs.sv
aux_req_arbiter.sv
aux_req_serializer.sv
aux_reply_parser.sv
dp_aux_link_top.sv
tb_dp_aux_link.sv

/* Makefile */
SIM     := verilator
TOP     := tb_dp_aux_link
RTL_TOP := dp_aux_link_top
FLIST   := vlog.f
FLAGS   := --binary --timing --assert -j 0
BIN     := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FLIST) $(wildcard *.sv *.svh)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
